// File: design/dcache_defines.svh
/*
 * Geometry of the L1 data cache.
 * Included by the packages and by every RTL module; the package types
 * derive their widths from these values.
 */

`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Associativity and number of sets
`define DCACHE_WAYS 4
`define DCACHE_SETS 16

// Line size, 32-bit words per line follow from it
`define DCACHE_LINE_BYTES 16
`define DCACHE_LINE_WORDS (`DCACHE_LINE_BYTES / 4)

// Address split: tag | set | offset
`define DCACHE_OFFSET_WIDTH 4
`define DCACHE_SET_WIDTH 4
`define DCACHE_ADDR_WIDTH 32

`endif

// File: design/dcache_pkg.sv
/*
 * Storage types of the L1 data cache: tags, set and way indices, cache
 * lines, the address split and the line fill from the next level.
 * Import with a wildcard where any of these types is needed.
 */

`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_WIDTH - `DCACHE_SET_WIDTH - `DCACHE_OFFSET_WIDTH - 1:0]
        dcache_tag_t;
    typedef logic [`DCACHE_SET_WIDTH - 1:0] dcache_set_idx_t;
    typedef logic [$clog2(`DCACHE_WAYS) - 1:0] dcache_way_idx_t;

    // Byte k of a line sits at bits 8k+7:8k
    typedef logic [`DCACHE_LINE_BYTES * 8 - 1:0] cache_line_t;

    typedef struct packed
    {
        dcache_tag_t tag;
        dcache_set_idx_t set_idx;
        logic [`DCACHE_OFFSET_WIDTH - 1:0] offset;
    } line_addr_t;

    // Address of a whole line, offset removed
    typedef logic [`DCACHE_ADDR_WIDTH - `DCACHE_OFFSET_WIDTH - 1:0] line_index_t;

    // Fill from the next level, writes tag, valid bit and data of one way
    typedef struct packed
    {
        logic en;
        dcache_way_idx_t way;
        dcache_set_idx_t set_idx;
        dcache_tag_t tag;
        cache_line_t data;
    } dcache_fill_t;

endpackage

`default_nettype wire

// File: design/mem_op_pkg.sv
/*
 * Memory-operation types: the request into the cache and the response,
 * write-through store and load miss that come out of it.
 * Builds on the storage types of the cache package.
 */

`default_nettype none

`include "dcache_defines.svh"

package mem_op_pkg;

    import dcache_pkg::*;

    typedef enum logic [1:0]
    {
        MEM_B,
        MEM_S,
        MEM_L,
        MEM_BLOCK
    } mem_access_t;

    // One bit per line word, bit j selects word j
    typedef logic [`DCACHE_LINE_WORDS - 1:0] lane_mask_t;

    typedef struct packed
    {
        logic valid;
        logic is_load;
        mem_access_t access;
        line_addr_t addr;
        lane_mask_t lane_mask;
        logic [`DCACHE_LINE_WORDS - 1:0][31:0] store_value;
    } mem_req_t;

    typedef struct packed
    {
        logic valid;
        logic is_load;
        logic hit;
        logic fault;
        cache_line_t load_data;
    } mem_resp_t;

    typedef struct packed
    {
        logic en;
        line_index_t line;
        logic [`DCACHE_LINE_BYTES - 1:0] byte_mask;
        cache_line_t data;
    } store_req_t;

    typedef struct packed
    {
        logic en;
        line_index_t line;
    } miss_req_t;

endpackage

`default_nettype wire

// File: design/sram_1r1w.sv
/*
 * Synchronous memory with one read and one write port.
 * Read data is registered and appears the cycle after read_en. A read of
 * the address being written in the same cycle returns the new data.
 * The payload type is a parameter, so tags and lines share this block.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module sram_1r1w
#(
    parameter type DATA_T = logic [31:0],
    parameter int SIZE = 64,
    localparam int ADDR_WIDTH = $clog2(SIZE)
)
(
    input wire clk,

    input wire read_en,
    input wire [ADDR_WIDTH - 1:0] read_addr,
    output DATA_T read_data,

    input wire write_en,
    input wire [ADDR_WIDTH - 1:0] write_addr,
    input DATA_T write_data
);

    DATA_T mem[SIZE];

    always_ff @(posedge clk)
    begin
        if (write_en)
            mem[write_addr] <= write_data;

        if (read_en)
        begin
            // Forward the word being written
            if (write_en && write_addr == read_addr)
                read_data <= write_data;
            else
                read_data <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

// File: design/store_aligner.sv
/*
 * Store alignment for the data stage.
 * From a request, forms the 16-bit byte mask and the line-wide store data
 * in big-endian byte order, and flags accesses that are not aligned to
 * their size. Purely combinational.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module store_aligner
    import dcache_pkg::*, mem_op_pkg::*;
(
    input mem_req_t req,
    output logic [`DCACHE_LINE_BYTES - 1:0] byte_mask,
    output cache_line_t data,
    output logic unaligned
);

    logic [1:0] byte_offset;
    logic [`DCACHE_OFFSET_WIDTH - 3:0] word_idx;
    logic [31:0] scalar_value;
    lane_mask_t word_mask;
    logic [3:0] word_byte_mask;
    cache_line_t block_data;

    assign byte_offset = req.addr.offset[1:0];
    assign word_idx = req.addr.offset[`DCACHE_OFFSET_WIDTH - 1:2];
    assign scalar_value = req.store_value[0];

    // Block data, each word with its most significant byte at the lowest address
    always_comb
    begin
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++)
        begin
            block_data[w * 32 +: 32] = {req.store_value[w][7:0], req.store_value[w][15:8],
                req.store_value[w][23:16], req.store_value[w][31:24]};
        end
    end

    always_comb
    begin
        word_mask = lane_mask_t'(1) << word_idx;
        case (req.access)
            MEM_B:
            begin
                word_byte_mask = 4'b0001 << byte_offset;
                data = {`DCACHE_LINE_BYTES{scalar_value[7:0]}};
            end
            MEM_S:
            begin
                word_byte_mask = 4'b0011 << byte_offset;
                data = {(`DCACHE_LINE_BYTES / 2){scalar_value[7:0], scalar_value[15:8]}};
            end
            MEM_L:
            begin
                word_byte_mask = 4'b1111;
                data = {`DCACHE_LINE_WORDS{scalar_value[7:0], scalar_value[15:8],
                    scalar_value[23:16], scalar_value[31:24]}};
            end
            default:
            begin
                // Block store, words picked by the lane mask
                word_mask = req.lane_mask;
                word_byte_mask = 4'b1111;
                data = block_data;
            end
        endcase
    end

    always_comb
    begin
        for (int k = 0; k < `DCACHE_LINE_BYTES; k++)
            byte_mask[k] = word_mask[k / 4] & word_byte_mask[k % 4];
    end

    always_comb
    begin
        case (req.access)
            MEM_S: unaligned = req.addr.offset[0];
            MEM_L: unaligned = |req.addr.offset[1:0];
            MEM_BLOCK: unaligned = req.addr.offset != '0;
            default: unaligned = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/dcache_tag_stage.sv
/*
 * First stage of the data cache pipeline.
 * Registers the incoming request and reads the tag and valid bit of every
 * way in the request's set. Holds the valid bits and one tag memory per
 * way, both written by line fills.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_tag_stage
    import dcache_pkg::*, mem_op_pkg::*;
(
    input wire clk,
    input wire reset,

    // Request and fill from outside
    input mem_req_t req,
    input dcache_fill_t fill,

    // To the data stage
    output mem_req_t dt_req,
    output dcache_tag_t dt_tag[`DCACHE_WAYS],
    output logic [`DCACHE_WAYS - 1:0] dt_valid
);

    logic [`DCACHE_WAYS - 1:0] valid_bits[`DCACHE_SETS];
    logic req_valid_q;
    mem_req_t req_q;

    // Tag memory per way, read with the incoming set index
    for (genvar way = 0; way < `DCACHE_WAYS; way++)
    begin : tag_way_gen
        sram_1r1w #(
            .DATA_T(dcache_tag_t),
            .SIZE(`DCACHE_SETS)
        ) i_tag_mem (
            .clk(clk),
            .read_en(req.valid),
            .read_addr(req.addr.set_idx),
            .read_data(dt_tag[way]),
            .write_en(fill.en && fill.way == dcache_way_idx_t'(way)),
            .write_addr(fill.set_idx),
            .write_data(fill.tag)
        );
    end

    // Valid bits, a fill marks its way valid
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int s = 0; s < `DCACHE_SETS; s++)
                valid_bits[s] <= '0;
        end
        else if (fill.en)
            valid_bits[fill.set_idx][fill.way] <= 1'b1;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            req_valid_q <= 1'b0;
            dt_valid <= '0;
        end
        else
        begin
            req_valid_q <= req.valid;
            if (req.valid)
                dt_valid <= valid_bits[req.addr.set_idx];
        end
    end

    // Request payload
    always_ff @(posedge clk)
    begin
        if (req.valid)
            req_q <= req;
    end

    always_comb
    begin
        dt_req = req_q;
        dt_req.valid = req_valid_q;
    end

endmodule

`default_nettype wire

// File: design/dcache_data_stage.sv
/*
 * Second stage of the data cache pipeline.
 * Compares the tags from the first stage, reads the line on an aligned
 * load hit and registers the response, the write-through store and the
 * load miss so they line up with the read data. Fills write the line memory.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_data_stage
    import dcache_pkg::*, mem_op_pkg::*;
(
    input wire clk,
    input wire reset,

    // From the tag stage
    input mem_req_t dt_req,
    input dcache_tag_t dt_tag[`DCACHE_WAYS],
    input wire [`DCACHE_WAYS - 1:0] dt_valid,

    input dcache_fill_t fill,

    output mem_resp_t resp,
    output store_req_t store,
    output miss_req_t miss
);

    logic [`DCACHE_WAYS - 1:0] way_hit_oh;
    dcache_way_idx_t way_hit_idx;
    logic cache_hit;
    logic load_en;
    logic line_read_en;
    logic [`DCACHE_LINE_BYTES - 1:0] store_mask;
    cache_line_t store_data;
    logic unaligned;
    cache_line_t line_rd_data;

    logic resp_valid_q;
    logic resp_is_load_q;
    logic resp_hit_q;
    logic resp_fault_q;
    logic store_en_q;
    logic miss_en_q;
    line_index_t line_q;
    logic [`DCACHE_LINE_BYTES - 1:0] store_mask_q;
    cache_line_t store_data_q;

    always_comb
    begin
        way_hit_idx = '0;
        for (int i = 0; i < `DCACHE_WAYS; i++)
        begin
            way_hit_oh[i] = dt_valid[i] && dt_tag[i] == dt_req.addr.tag;
            if (way_hit_oh[i])
                way_hit_idx = dcache_way_idx_t'(i);
        end
    end

    assign cache_hit = |way_hit_oh;
    assign load_en = dt_req.valid && dt_req.is_load;
    assign line_read_en = load_en && cache_hit && !unaligned;

    store_aligner i_store_aligner (
        .req(dt_req),
        .byte_mask(store_mask),
        .data(store_data),
        .unaligned(unaligned)
    );

    // Lines of all ways, addressed by {way, set}
    sram_1r1w #(
        .DATA_T(cache_line_t),
        .SIZE(`DCACHE_WAYS * `DCACHE_SETS)
    ) i_line_mem (
        .clk(clk),
        .read_en(line_read_en),
        .read_addr({way_hit_idx, dt_req.addr.set_idx}),
        .read_data(line_rd_data),
        .write_en(fill.en),
        .write_addr({fill.way, fill.set_idx}),
        .write_data(fill.data)
    );

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            resp_valid_q <= 1'b0;
            resp_hit_q <= 1'b0;
            resp_fault_q <= 1'b0;
            store_en_q <= 1'b0;
            miss_en_q <= 1'b0;
        end
        else
        begin
            resp_valid_q <= dt_req.valid;
            resp_hit_q <= line_read_en;
            resp_fault_q <= dt_req.valid && unaligned;
            // Stores go through whether or not the line is present
            store_en_q <= dt_req.valid && !dt_req.is_load && !unaligned && |store_mask;
            miss_en_q <= load_en && !cache_hit && !unaligned;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dt_req.valid)
        begin
            resp_is_load_q <= dt_req.is_load;
            line_q <= {dt_req.addr.tag, dt_req.addr.set_idx};
            store_mask_q <= store_mask;
            store_data_q <= store_data;
        end
    end

    always_comb
    begin
        resp.valid = resp_valid_q;
        resp.is_load = resp_is_load_q;
        resp.hit = resp_hit_q;
        resp.fault = resp_fault_q;
        resp.load_data = line_rd_data;

        store.en = store_en_q;
        store.line = line_q;
        store.byte_mask = store_mask_q;
        store.data = store_data_q;

        miss.en = miss_en_q;
        miss.line = line_q;
    end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
/*
 * L1 data cache, two-stage pipeline.
 * A request sampled at one edge gives its response, store and miss two
 * edges later. Requests are accepted whenever valid is high, fills
 * whenever en is high; there is no back-pressure.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_top
    import dcache_pkg::*, mem_op_pkg::*;
(
    input wire clk,
    input wire reset,

    // Memory request and line fill
    input mem_req_t req,
    input dcache_fill_t fill,

    // Results, two cycles after the request
    output mem_resp_t resp,
    output store_req_t store,
    output miss_req_t miss
);

    mem_req_t dt_req;
    dcache_tag_t dt_tag[`DCACHE_WAYS];
    logic [`DCACHE_WAYS - 1:0] dt_valid;

    dcache_tag_stage i_tag_stage (
        .clk(clk),
        .reset(reset),
        .req(req),
        .fill(fill),
        .dt_req(dt_req),
        .dt_tag(dt_tag),
        .dt_valid(dt_valid)
    );

    dcache_data_stage i_data_stage (
        .clk(clk),
        .reset(reset),
        .dt_req(dt_req),
        .dt_tag(dt_tag),
        .dt_valid(dt_valid),
        .fill(fill),
        .resp(resp),
        .store(store),
        .miss(miss)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
/*
 * Clock and power-on reset for the testbench.
 * 10 ns clock; reset is high from time zero for three rising edges.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/dcache_props.sv
/*
 * Concurrent assertions on the data cache outputs.
 * Bound to dcache_top; each failure raises $error and adds to a count.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_props
    import dcache_pkg::*, mem_op_pkg::*;
(
    input wire clk,
    input wire reset,
    input mem_req_t req,
    input mem_resp_t resp,
    input store_req_t store,
    input miss_req_t miss,
    input wire [`DCACHE_WAYS - 1:0] way_hit_oh
);

    int fail_count = 0;

    store_miss_excl: assert property (@(posedge clk) disable iff (reset)
        !(store.en && miss.en))
    else
    begin
        $error("store.en and miss.en high together");
        fail_count++;
    end

    fault_excl: assert property (@(posedge clk) disable iff (reset)
        resp.fault |-> !store.en && !miss.en)
    else
    begin
        $error("resp.fault with store.en or miss.en");
        fail_count++;
    end

    // Registered at edge N+1, the response is sampled at edge N+2
    resp_latency: assert property (@(posedge clk)
        !reset && !$past(reset, 1) && !$past(reset, 2)
        |-> resp.valid == $past(req.valid, 2))
    else
    begin
        $error("resp.valid does not follow req.valid");
        fail_count++;
    end

    way_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(way_hit_oh))
    else
    begin
        $error("way-hit vector has more than one bit set");
        fail_count++;
    end

endmodule

bind dcache_top dcache_props i_props (
    .clk(clk),
    .reset(reset),
    .req(req),
    .resp(resp),
    .store(store),
    .miss(miss),
    .way_hit_oh(i_data_stage.way_hit_oh)
);

`default_nettype wire

// File: verif/tb_top.sv
/*
 * Testbench for the two-stage L1 data cache.
 * A reference model mirrors tags and lines from the fills, predicts each
 * request and checks the outputs two edges later at the falling edge.
 * Runs the load, way, store, block, unaligned and reset tests in turn.
 */

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module tb_top
    import dcache_pkg::*, mem_op_pkg::*;
;

    localparam int TIMEOUT = 20;

    typedef struct packed
    {
        logic valid;
        logic is_load;
        logic hit;
        logic fault;
        cache_line_t load_data;
        logic store_en;
        logic [`DCACHE_LINE_BYTES - 1:0] byte_mask;
        cache_line_t store_data;
        logic miss_en;
        line_index_t line;
    } expected_t;

    logic clk;
    logic por_reset;
    logic test_reset;
    logic reset;
    mem_req_t req;
    dcache_fill_t fill;
    mem_resp_t resp;
    store_req_t store;
    miss_req_t miss;

    // Reference model state
    dcache_tag_t mirror_tag[`DCACHE_SETS][`DCACHE_WAYS];
    cache_line_t mirror_line[`DCACHE_SETS][`DCACHE_WAYS];
    logic [`DCACHE_WAYS - 1:0] mirror_valid[`DCACHE_SETS];
    expected_t exp_q[$];
    expected_t cur_exp = '0;

    logic [31:0] lfsr_state = 32'h49c24e50;
    int checks = 0;
    int errors = 0;
    int errors_before = 0;
    int tests = 0;

    assign reset = por_reset | test_reset;

    tb_clock_gen i_clock_gen (
        .clk(clk),
        .reset(por_reset)
    );

    dcache_top i_dut (
        .clk(clk),
        .reset(reset),
        .req(req),
        .fill(fill),
        .resp(resp),
        .store(store),
        .miss(miss)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic cache_line_t random_line();
        return {random_bits(32), random_bits(32), random_bits(32), random_bits(32)};
    endfunction

    // Expected outputs of one request against the mirror
    function automatic expected_t predict(mem_req_t r);
        expected_t e;
        int off;
        int b;
        logic bad;
        logic hit;
        e = '0;
        hit = 1'b0;
        off = int'(r.addr.offset);
        case (r.access)
            MEM_S: bad = off % 2 != 0;
            MEM_L: bad = off % 4 != 0;
            MEM_BLOCK: bad = off != 0;
            default: bad = 1'b0;
        endcase
        for (int w = 0; w < `DCACHE_WAYS; w++)
        begin
            if (mirror_valid[r.addr.set_idx][w] && mirror_tag[r.addr.set_idx][w] == r.addr.tag)
            begin
                hit = 1'b1;
                e.load_data = mirror_line[r.addr.set_idx][w];
            end
        end
        for (int k = 0; k < `DCACHE_LINE_BYTES; k++)
        begin
            b = k % 4;
            case (r.access)
                MEM_B: e.byte_mask[k] = k == off;
                MEM_S: e.byte_mask[k] = k == off || k == off + 1;
                MEM_L: e.byte_mask[k] = k / 4 == off / 4;
                default: e.byte_mask[k] = r.lane_mask[k / 4];
            endcase
            // Lowest byte address holds the most significant byte
            case (r.access)
                MEM_B: e.store_data[8 * k +: 8] = r.store_value[0][7:0];
                MEM_S: e.store_data[8 * k +: 8] = r.store_value[0][15 - 8 * (k % 2) -: 8];
                MEM_L: e.store_data[8 * k +: 8] = r.store_value[0][31 - 8 * b -: 8];
                default: e.store_data[8 * k +: 8] = r.store_value[k / 4][31 - 8 * b -: 8];
            endcase
        end
        e.valid = r.valid;
        e.is_load = r.is_load;
        e.fault = r.valid && bad;
        e.hit = r.valid && r.is_load && !bad && hit;
        e.miss_en = r.valid && r.is_load && !bad && !hit;
        e.store_en = r.valid && !r.is_load && !bad && |e.byte_mask;
        e.line = {r.addr.tag, r.addr.set_idx};
        return e;
    endfunction

    function automatic int in_flight();
        int n;
        n = int'(cur_exp.valid);
        foreach (exp_q[i])
            n += int'(exp_q[i].valid);
        return n;
    endfunction

    // Model pipeline, a fill counts only for later requests
    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            exp_q.delete();
            cur_exp = '0;
            for (int s = 0; s < `DCACHE_SETS; s++)
                mirror_valid[s] = '0;
        end
        else
        begin
            exp_q.push_back(predict(req));
            if (exp_q.size() == 2)
                cur_exp = exp_q.pop_front();
            else
                cur_exp = '0;
            if (fill.en)
            begin
                mirror_valid[fill.set_idx][fill.way] = 1'b1;
                mirror_tag[fill.set_idx][fill.way] = fill.tag;
                mirror_line[fill.set_idx][fill.way] = fill.data;
            end
        end
    end

    task automatic check_bit(string name, logic got, logic want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic check_line(string name, cache_line_t got, cache_line_t want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, want);
        end
    endtask

    always @(negedge clk)
    begin
        check_bit("resp.valid", resp.valid, cur_exp.valid);
        check_bit("store.en", store.en, cur_exp.store_en);
        check_bit("miss.en", miss.en, cur_exp.miss_en);
        if (cur_exp.valid)
        begin
            check_bit("resp.is_load", resp.is_load, cur_exp.is_load);
            check_bit("resp.fault", resp.fault, cur_exp.fault);
            check_bit("resp.hit", resp.hit, cur_exp.hit);
        end
        if (cur_exp.hit)
            check_line("resp.load_data", resp.load_data, cur_exp.load_data);
        if (cur_exp.store_en)
        begin
            check_line("store.line", cache_line_t'(store.line), cache_line_t'(cur_exp.line));
            check_line("store.byte_mask", cache_line_t'(store.byte_mask),
                cache_line_t'(cur_exp.byte_mask));
            check_line("store.data", store.data, cur_exp.store_data);
        end
        if (cur_exp.miss_en)
            check_line("miss.line", cache_line_t'(miss.line), cache_line_t'(cur_exp.line));
    end

    task automatic timeout_fail(string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic issue(logic is_load, mem_access_t access, logic [31:0] addr,
        lane_mask_t lanes, cache_line_t value);
        mem_req_t r;
        r.valid = 1'b1;
        r.is_load = is_load;
        r.access = access;
        r.addr = line_addr_t'(addr);
        r.lane_mask = lanes;
        r.store_value = value;
        @(posedge clk);
        req <= r;
    endtask

    task automatic fill_line(int way, logic [31:0] addr, cache_line_t data);
        dcache_fill_t f;
        line_addr_t a;
        a = line_addr_t'(addr);
        f.en = 1'b1;
        f.way = dcache_way_idx_t'(way);
        f.set_idx = a.set_idx;
        f.tag = a.tag;
        f.data = data;
        @(posedge clk);
        fill <= f;
        @(posedge clk);
        fill <= '0;
    endtask

    // Idle the request port until every prediction has been checked
    task automatic drain();
        int cycles;
        cycles = 0;
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        while (in_flight() != 0 && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (in_flight() != 0)
            timeout_fail("the pipeline to drain");
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

    initial
    begin
        logic [31:0] base;
        logic [31:0] lines[`DCACHE_WAYS];
        int cycles;
        req = '0;
        fill = '0;
        test_reset = 1'b0;
        cycles = 0;
        while (reset && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (reset)
            timeout_fail("reset release");

        // Miss first, then hits in back-to-back cycles
        base = (random_bits(24) << 8) | 32'h30;
        issue(1'b1, MEM_L, base, '0, '0);
        drain();
        fill_line(0, base, random_line());
        issue(1'b1, MEM_L, base, '0, '0);
        issue(1'b1, MEM_B, base + 5, '0, '0);
        issue(1'b1, MEM_BLOCK, base, '0, '0);
        drain();
        end_test("load miss then hit");

        for (int w = 0; w < `DCACHE_WAYS; w++)
        begin
            lines[w] = (32'(w) << 30) | (random_bits(22) << 8) | 32'h70;
            fill_line(w, lines[w], random_line());
        end
        for (int w = 0; w < `DCACHE_WAYS; w++)
            issue(1'b1, MEM_L, lines[w] + 32'(4 * w), '0, '0);
        issue(1'b1, MEM_L, lines[0] ^ 32'h0100_0000, '0, '0);
        drain();
        end_test("way selection");

        for (int o = 0; o < `DCACHE_LINE_BYTES; o++)
            issue(1'b0, MEM_B, base + o, '0, random_line());
        for (int o = 0; o < `DCACHE_LINE_BYTES; o += 2)
            issue(1'b0, MEM_S, base + o, '0, random_line());
        for (int o = 0; o < `DCACHE_LINE_BYTES; o += 4)
            issue(1'b0, MEM_L, base + o, '0, random_line());
        issue(1'b0, MEM_L, random_bits(32) & 32'hffff_fffc, '0, random_line());
        drain();
        end_test("scalar stores");

        for (int i = 0; i < 8; i++)
            issue(1'b0, MEM_BLOCK, random_bits(28) << 4, lane_mask_t'(random_bits(4)),
                random_line());
        issue(1'b0, MEM_BLOCK, base, '0, random_line());
        drain();
        end_test("block store");

        for (int o = 1; o < `DCACHE_LINE_BYTES; o += 2)
        begin
            issue(1'b0, MEM_S, base + o, '0, random_line());
            issue(1'b1, MEM_S, base + o, '0, '0);
        end
        issue(1'b0, MEM_L, base + 2, '0, random_line());
        issue(1'b1, MEM_L, base + 6, '0, '0);
        issue(1'b0, MEM_BLOCK, base + 4, 4'hf, random_line());
        issue(1'b1, MEM_BLOCK, base + 8, '0, '0);
        drain();
        end_test("unaligned access");

        // Reset with requests in flight and arriving during reset
        issue(1'b1, MEM_L, base, '0, '0);
        issue(1'b0, MEM_L, base, '0, random_line());
        @(posedge clk);
        test_reset <= 1'b1;
        issue(1'b1, MEM_L, lines[1], '0, '0);
        issue(1'b0, MEM_B, base, '0, random_line());
        @(posedge clk);
        test_reset <= 1'b0;
        req <= '0;
        issue(1'b1, MEM_L, base, '0, '0);
        for (int w = 0; w < `DCACHE_WAYS; w++)
            issue(1'b1, MEM_L, lines[w], '0, '0);
        drain();
        end_test("reset");

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
            tests, checks, errors, i_dut.i_props.fail_count);
        if (errors == 0 && i_dut.i_props.fail_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/dcache_pkg.sv
design/mem_op_pkg.sv
design/sram_1r1w.sv
design/store_aligner.sv
design/dcache_tag_stage.sv
design/dcache_data_stage.sv
design/dcache_top.sv
verif/tb_clock_gen.sv
verif/dcache_props.sv
verif/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_top -o sim_tb

# Assertion errors are counted by the testbench instead of stopping the run
./obj_dir/sim_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "^TESTS PASSED$" sim.log
then
    echo "Simulation log shows a passing run"
    exit 0
else
    echo "Simulation log shows a failing run"
    exit 1
fi
